// ==== rtl/pin_seq_pkg.sv ====
package pin_seq_pkg;

    // address bits 11:8 pick a channel or the global block
    localparam logic [3:0] GLOBAL_SEL = 4'd15;

    // channel register words sit in address bits 7:2
    localparam logic [4:0] REG_NCO_STEP    = 5'd0;
    localparam logic [4:0] REG_END_TIME    = 5'd1;
    localparam logic [4:0] REG_CMD         = 5'd2;
    localparam logic [4:0] REG_SAMPLE_RATE = 5'd3;
    localparam logic [4:0] REG_REC_START   = 5'd4;
    localparam logic [4:0] REG_STATUS      = 5'd5; // read only
    localparam int         NUM_REGS        = 6;
    localparam int         REG_SEL_W       = $clog2(NUM_REGS);

    localparam logic [5:0] REG_CTRL       = 6'd0; // bit 0 sets run and bit 1 clears the time
    localparam logic [5:0] REG_TIME       = 6'd1;
    localparam logic [5:0] REG_FIFO_DATA  = 6'd2; // a read pops one word
    localparam logic [5:0] REG_FIFO_COUNT = 6'd3;

    localparam logic [31:0] CMD_CONST  = 32'd2;
    localparam logic [31:0] CMD_SQUARE = 32'd3;
    localparam logic [31:0] CMD_STREAM = 32'd4;
    localparam logic [31:0] CMD_STOP   = 32'd5;

    // one-hot channel states that also form the low bits of REG_STATUS
    localparam logic [3:0] ST_IDLE   = 4'b0001;
    localparam logic [3:0] ST_CONST  = 4'b0010;
    localparam logic [3:0] ST_SQUARE = 4'b0100;
    localparam logic [3:0] ST_STREAM = 4'b1000;
    localparam int STATUS_OVERRUN_BIT = 4;

    localparam int COUNT_W = 16; // width of the fifo fill count

    typedef struct packed {
        logic        valid;
        logic [3:0]  chan;
        logic [4:0]  reg_idx;
        logic [31:0] data;
    } chan_wr_t;

    typedef struct packed {
        logic [15:0] count;
        logic [14:0] chan;
        logic        level;
    } sample_word_t;

endpackage

// ==== rtl/time_base.sv ====
`timescale 1ns/1ps

module time_base (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        time_clear,
    output logic [31:0] current_time
);

    // every channel compares against this one count, so end times line up
    always_ff @(posedge clk) begin
        if (reset)
            current_time <= '0;
        else if (time_clear)
            current_time <= '0; // a clear wins over a running count
        else if (run)
            current_time <= current_time + 32'd1;
    end

endmodule

// ==== rtl/axil_reg_port.sv ====
`timescale 1ns/1ps

module axil_reg_port #(
    parameter int NUM_PINS = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [11:0]             s_axil_awaddr,
    input  logic                    s_axil_awvalid,
    output logic                    s_axil_awready,
    input  logic [31:0]             s_axil_wdata,
    input  logic                    s_axil_wvalid,
    output logic                    s_axil_wready,
    output logic [1:0]              s_axil_bresp,
    output logic                    s_axil_bvalid,
    input  logic                    s_axil_bready,
    input  logic [11:0]             s_axil_araddr,
    input  logic                    s_axil_arvalid,
    output logic                    s_axil_arready,
    output logic [31:0]             s_axil_rdata,
    output logic [1:0]              s_axil_rresp,
    output logic                    s_axil_rvalid,
    input  logic                    s_axil_rready,
    output pin_seq_pkg::chan_wr_t   chan_wr,
    output logic                    run,
    output logic                    time_clear,
    input  logic [31:0]             current_time,
    input  logic [NUM_PINS-1:0][pin_seq_pkg::NUM_REGS-1:0][31:0] chan_status,
    output logic                    fifo_pop,
    input  pin_seq_pkg::sample_word_t fifo_rdata,
    input  logic [pin_seq_pkg::COUNT_W-1:0] fifo_count,
    input  logic                    fifo_empty
);
    import pin_seq_pkg::*;

    localparam int UNIT_W = NUM_PINS > 1 ? $clog2(NUM_PINS) : 1;

    logic        wr_hs;
    logic        rd_hs;
    logic [3:0]  wr_unit;
    logic [3:0]  rd_unit;
    logic [5:0]  wr_word;
    logic [5:0]  rd_word;
    logic        wr_ctrl;
    logic        rd_global;
    logic [31:0] rd_value;

    assign wr_unit = s_axil_awaddr[11:8];
    assign wr_word = s_axil_awaddr[7:2];
    assign rd_unit = s_axil_araddr[11:8];
    assign rd_word = s_axil_araddr[7:2];

    // address and data are taken together, and only with no response pending
    assign wr_hs          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_hs;
    assign s_axil_wready  = wr_hs;
    assign s_axil_bresp   = 2'b00;
    assign wr_ctrl        = wr_unit == GLOBAL_SEL && wr_word == REG_CTRL;

    always_ff @(posedge clk) begin
        if (reset) begin
            s_axil_bvalid <= 1'b0;
            chan_wr       <= '0;
            run           <= 1'b0;
            time_clear    <= 1'b0;
        end else begin
            chan_wr.valid   <= wr_hs && int'(wr_unit) < NUM_PINS && !wr_word[5];
            chan_wr.chan    <= wr_unit;
            chan_wr.reg_idx <= wr_word[4:0];
            chan_wr.data    <= s_axil_wdata;
            time_clear      <= wr_hs && wr_ctrl && s_axil_wdata[1]; // one-cycle pulse
            if (wr_hs && wr_ctrl)
                run <= s_axil_wdata[0];
            if (wr_hs)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;
        end
    end

    assign s_axil_arready = !s_axil_rvalid;
    assign s_axil_rresp   = 2'b00;
    assign rd_hs          = s_axil_arvalid && !s_axil_rvalid;
    assign rd_global      = rd_unit == GLOBAL_SEL;
    // the popped word is the show-ahead head, so it is latched in the same cycle
    assign fifo_pop = rd_hs && rd_global && rd_word == REG_FIFO_DATA && !fifo_empty;

    always_comb begin
        rd_value = '0; // unmapped words read as zero
        if (rd_global) begin
            case (rd_word)
                REG_CTRL:       rd_value = {31'b0, run};
                REG_TIME:       rd_value = current_time;
                REG_FIFO_DATA:  rd_value = fifo_empty ? 32'b0 : fifo_rdata;
                REG_FIFO_COUNT: rd_value = 32'(fifo_count);
                default:        rd_value = '0;
            endcase
        end else if (int'(rd_unit) < NUM_PINS && int'(rd_word) < NUM_REGS) begin
            rd_value = chan_status[rd_unit[UNIT_W-1:0]][rd_word[REG_SEL_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            s_axil_rvalid <= 1'b0;
        else if (rd_hs)
            s_axil_rvalid <= 1'b1;
        else if (s_axil_rready)
            s_axil_rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_hs)
            s_axil_rdata <= rd_value;
    end

    assert property (@(posedge clk) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);
    assert property (@(posedge clk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

// ==== rtl/pin_channel.sv ====
`timescale 1ns/1ps

module pin_channel #(
    parameter int NUM_PINS   = 4,
    parameter int CHAN_INDEX = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  pin_seq_pkg::chan_wr_t     chan_wr,
    input  logic                      run,
    input  logic [31:0]               current_time,
    input  logic                      pin_in,
    output logic                      pin_out,
    output logic                      pin_oe,
    output pin_seq_pkg::sample_word_t sample,
    output logic                      pend,
    input  logic                      ack,
    output logic [pin_seq_pkg::NUM_REGS-1:0][31:0] status
);
    import pin_seq_pkg::*;

    localparam bit IN_RANGE = CHAN_INDEX < NUM_PINS;

    logic [31:0] nco_step;
    logic [31:0] end_time;
    logic [31:0] cmd;
    logic [31:0] sample_rate;
    logic [31:0] rec_start;
    logic [3:0]  state;
    logic [3:0]  state_nxt;
    logic        wr_hit;
    logic        clear_cmd;
    logic        at_end;
    logic        leave;
    logic [31:0] phase_acc;
    logic [31:0] ivl_cnt;
    logic        recording;
    logic        take_sample;
    logic [15:0] sample_cnt;
    logic        overrun;
    logic [31:0] status_word;

    assign wr_hit = IN_RANGE && chan_wr.valid && chan_wr.chan == 4'(CHAN_INDEX);

    always_ff @(posedge clk) begin
        if (reset) begin
            nco_step    <= '0;
            end_time    <= '0;
            cmd         <= '0;
            sample_rate <= '0;
            rec_start   <= '0;
        end else begin
            if (clear_cmd)
                cmd <= '0;
            if (wr_hit) begin
                case (chan_wr.reg_idx)
                    REG_NCO_STEP:    nco_step    <= chan_wr.data;
                    REG_END_TIME:    end_time    <= chan_wr.data;
                    REG_CMD:         cmd         <= chan_wr.data; // beats a clear in the same cycle
                    REG_SAMPLE_RATE: sample_rate <= chan_wr.data;
                    REG_REC_START:   rec_start   <= chan_wr.data;
                    default: ;
                endcase
            end
        end
    end

    // an end time of zero means the job runs until stopped
    assign at_end = end_time != '0 && current_time == end_time;

    always_comb begin
        state_nxt = state;
        clear_cmd = 1'b0;
        case (state)
            ST_IDLE: begin
                case (cmd)
                    CMD_CONST:  state_nxt = ST_CONST;
                    CMD_SQUARE: state_nxt = ST_SQUARE;
                    CMD_STREAM: state_nxt = ST_STREAM;
                    default:    state_nxt = ST_IDLE;
                endcase
                if (!run)
                    state_nxt = ST_IDLE; // commands wait for the time base
                clear_cmd = state_nxt != ST_IDLE || cmd == CMD_STOP;
            end
            ST_CONST, ST_SQUARE, ST_STREAM: begin
                if (cmd == CMD_STOP || at_end) begin
                    state_nxt = ST_IDLE;
                    clear_cmd = 1'b1;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    assign leave = state != ST_IDLE && state_nxt == ST_IDLE;

    always_ff @(posedge clk) begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // output frequency is about f_clk * nco_step / 2^32
    always_ff @(posedge clk) begin
        if (reset)
            phase_acc <= '0;
        else if (state == ST_SQUARE && !leave)
            phase_acc <= phase_acc + nco_step;
        else
            phase_acc <= '0;
    end

    assign pin_oe  = state == ST_CONST || state == ST_SQUARE;
    assign pin_out = state == ST_CONST || (state == ST_SQUARE && phase_acc[31]);

    // the first sample falls on rec_start, then one every sample_rate+1 cycles
    assign take_sample = state == ST_STREAM && !leave &&
                         (recording ? ivl_cnt == '0 : current_time == rec_start);

    always_ff @(posedge clk) begin
        if (reset || state != ST_STREAM || leave) begin
            recording  <= 1'b0;
            ivl_cnt    <= '0;
            sample_cnt <= '0;
        end else if (take_sample) begin
            recording  <= 1'b1;
            ivl_cnt    <= sample_rate;
            sample_cnt <= sample_cnt + 16'd1;
        end else if (recording) begin
            ivl_cnt <= ivl_cnt - 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend    <= 1'b0;
            overrun <= 1'b0;
        end else if (take_sample) begin
            pend <= 1'b1;
            if (pend && !ack)
                overrun <= 1'b1; // the older record is replaced before the collector took it
        end else if (ack) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_sample) begin
            sample.count <= sample_cnt + 16'd1;
            sample.chan  <= 15'(CHAN_INDEX);
            sample.level <= pin_in;
        end
    end

    always_comb begin
        status_word = {28'b0, state};
        status_word[STATUS_OVERRUN_BIT] = overrun;
    end

    // word order follows the REG_* indices, lowest word first
    assign status = {status_word, rec_start, sample_rate, cmd, end_time, nco_step};

    assert property (@(posedge clk) disable iff (reset) $onehot(state));
    assert property (@(posedge clk) disable iff (reset) !pin_oe |-> !pin_out);

endmodule

// ==== rtl/sample_collector.sv ====
`timescale 1ns/1ps

module sample_collector #(
    parameter int NUM_PINS = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  pin_seq_pkg::sample_word_t [NUM_PINS-1:0] samples,
    input  logic [NUM_PINS-1:0]                      pends,
    output logic [NUM_PINS-1:0]                      acks,
    input  logic                                     fifo_full,
    output logic                                     push,
    output pin_seq_pkg::sample_word_t                push_data
);

    localparam int PTR_W = NUM_PINS > 1 ? $clog2(NUM_PINS) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] grant;
    logic             found;

    // first pending channel at or after the pointer, wrapping around
    always_comb begin
        int idx;
        found = 1'b0;
        grant = ptr;
        for (int i = 0; i < NUM_PINS; i++) begin
            idx = (int'(ptr) + i) % NUM_PINS;
            if (!found && pends[idx]) begin
                found = 1'b1;
                grant = PTR_W'(idx);
            end
        end
    end

    assign push      = found && !fifo_full; // a full fifo holds every record in its channel
    assign push_data = samples[grant];

    always_comb begin
        acks = '0;
        if (push)
            acks[grant] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            ptr <= '0;
        else if (push)
            ptr <= (grant == PTR_W'(NUM_PINS - 1)) ? '0 : grant + 1'b1;
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(acks));

endmodule

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            push,
    input  pin_seq_pkg::sample_word_t       push_data,
    input  logic                            pop,
    output pin_seq_pkg::sample_word_t       rdata,
    output logic [pin_seq_pkg::COUNT_W-1:0] count,
    output logic                            full,
    output logic                            empty
);
    import pin_seq_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    sample_word_t mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   fill;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign rdata = mem[rd_ptr]; // head word is visible before the pop
    assign full  = fill == (AW+1)'(FIFO_DEPTH);
    assign empty = fill == '0;
    assign count = COUNT_W'(fill);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two so pointers wrap
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // the collector and the register port are expected to check the flags
    assert property (@(posedge clk) disable iff (reset) push |-> !full);
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// ==== rtl/pin_seq_top.sv ====
`timescale 1ns/1ps

module pin_seq_top #(
    parameter int NUM_PINS   = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [11:0]         s_axil_awaddr,
    input  logic                s_axil_awvalid,
    output logic                s_axil_awready,
    input  logic [31:0]         s_axil_wdata,
    input  logic                s_axil_wvalid,
    output logic                s_axil_wready,
    output logic [1:0]          s_axil_bresp,
    output logic                s_axil_bvalid,
    input  logic                s_axil_bready,
    input  logic [11:0]         s_axil_araddr,
    input  logic                s_axil_arvalid,
    output logic                s_axil_arready,
    output logic [31:0]         s_axil_rdata,
    output logic [1:0]          s_axil_rresp,
    output logic                s_axil_rvalid,
    input  logic                s_axil_rready,
    input  logic [NUM_PINS-1:0] pin_in,
    output logic [NUM_PINS-1:0] pin_out,
    output logic [NUM_PINS-1:0] pin_oe
);
    import pin_seq_pkg::*;

    chan_wr_t                               chan_wr;
    logic                                   run;
    logic                                   time_clear;
    logic [31:0]                            current_time;
    logic [NUM_PINS-1:0][NUM_REGS-1:0][31:0] chan_status;
    sample_word_t [NUM_PINS-1:0]            samples;
    logic [NUM_PINS-1:0]                    pends;
    logic [NUM_PINS-1:0]                    acks;
    logic                                   push;
    sample_word_t                           push_data;
    logic                                   fifo_pop;
    sample_word_t                           fifo_rdata;
    logic [COUNT_W-1:0]                     fifo_count;
    logic                                   fifo_full;
    logic                                   fifo_empty;

    axil_reg_port #(.NUM_PINS(NUM_PINS)) axil0 (
        .clk, .reset,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
        .chan_wr, .run, .time_clear, .current_time, .chan_status,
        .fifo_pop, .fifo_rdata, .fifo_count, .fifo_empty
    );

    time_base time0 (.clk, .reset, .run, .time_clear, .current_time);

    for (genvar i = 0; i < NUM_PINS; i++) begin : gen_chan
        pin_channel #(.NUM_PINS(NUM_PINS), .CHAN_INDEX(i)) chan (
            .clk, .reset, .chan_wr, .run, .current_time,
            .pin_in(pin_in[i]), .pin_out(pin_out[i]), .pin_oe(pin_oe[i]),
            .sample(samples[i]), .pend(pends[i]), .ack(acks[i]),
            .status(chan_status[i])
        );
    end

    sample_collector #(.NUM_PINS(NUM_PINS)) coll0 (
        .clk, .reset, .samples, .pends, .acks,
        .fifo_full, .push, .push_data
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
        .clk, .reset, .push, .push_data, .pop(fifo_pop),
        .rdata(fifo_rdata), .count(fifo_count), .full(fifo_full), .empty(fifo_empty)
    );

endmodule

// ==== tb/tb_pin_seq.sv ====
`timescale 1ns/1ps

module tb_pin_seq;
    import pin_seq_pkg::*;

    localparam int NUM_PINS    = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int CYCLE_LIMIT = 4000; // about twice what the tests below need

    logic                clk;
    logic                reset;
    logic [11:0]         s_axil_awaddr;
    logic                s_axil_awvalid;
    logic                s_axil_awready;
    logic [31:0]         s_axil_wdata;
    logic                s_axil_wvalid;
    logic                s_axil_wready;
    logic [1:0]          s_axil_bresp;
    logic                s_axil_bvalid;
    logic                s_axil_bready;
    logic [11:0]         s_axil_araddr;
    logic                s_axil_arvalid;
    logic                s_axil_arready;
    logic [31:0]         s_axil_rdata;
    logic [1:0]          s_axil_rresp;
    logic                s_axil_rvalid;
    logic                s_axil_rready;
    logic [NUM_PINS-1:0] pin_in;
    logic [NUM_PINS-1:0] pin_out;
    logic [NUM_PINS-1:0] pin_oe;

    logic [NUM_PINS-1:0] pin_level;    // what the outside world drives onto each pin
    integer              seed;
    int                  cycles = 0;
    int                  last_count [NUM_PINS];
    int                  cmp_count;
    int                  cmp_chan;
    logic                cmp_level;
    logic                cmp_busy = 1'b0;

    assign pin_in = pin_level;

    pin_seq_top #(.NUM_PINS(NUM_PINS), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
        .clk, .reset,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
        .pin_in, .pin_out, .pin_oe
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            report_failure();
        end
    end

    function automatic logic [11:0] channel_addr(input int chan, input logic [4:0] idx);
        return {4'(chan), 1'b0, idx, 2'b00};
    endfunction

    function automatic logic [11:0] global_addr(input logic [5:0] word);
        return {GLOBAL_SEL, word, 2'b00};
    endfunction

    // a sample record holds the count on top, then the channel, then the pin level
    function automatic sample_word_t expected_sample(input int chan, input int n,
                                                     input logic level);
        sample_word_t w;
        w.count = 16'(n);
        w.chan  = 15'(chan);
        w.level = level;
        return w;
    endfunction

    task automatic report_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            report_failure();
        end
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        #1;
        check_value("s_axil_awready", 32'(s_axil_awready), 32'd1);
        check_value("s_axil_wready", 32'(s_axil_wready), 32'd1);
        @(negedge clk);
        while (!s_axil_bvalid) @(negedge clk);
        check_value("s_axil_bresp", 32'(s_axil_bresp), 32'd0);
        check_value("s_axil_awready", 32'(s_axil_awready), 32'd0); // a response is pending
        s_axil_awvalid = 1'b0; // bready is held high, so the response ends at the next edge
        s_axil_wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        #1;
        check_value("s_axil_arready", 32'(s_axil_arready), 32'd1);
        @(negedge clk);
        while (!s_axil_rvalid) @(negedge clk);
        check_value("s_axil_rresp", 32'(s_axil_rresp), 32'd0);
        check_value("s_axil_arready", 32'(s_axil_arready), 32'd0);
        data           = s_axil_rdata;
        s_axil_arvalid = 1'b0;
    endtask

    task automatic wait_oe(input int idx, input logic level);
        int n;
        n = 0;
        while (pin_oe[idx] !== level && n < 32) begin
            @(negedge clk);
            n++;
        end
        check_value($sformatf("pin_oe[%0d]", idx), 32'(pin_oe[idx]), 32'(level));
    endtask

    task automatic wait_time_past(input logic [31:0] limit);
        logic [31:0] t;
        t = '0;
        while (t <= limit)
            axil_read(global_addr(REG_TIME), t);
    endtask

    // pops one word of the two-channel stream and checks that counts rise within a channel
    task automatic pop_stream_word();
        logic [31:0]  raw;
        sample_word_t w;
        int           ch;
        axil_read(global_addr(REG_FIFO_DATA), raw);
        w  = raw;
        ch = int'(w.chan);
        if (ch != 0 && ch != 2) begin
            $display("a sample came from channel %0d while only channels 0 and 2 stream", ch);
            report_failure();
        end
        check_value("sample.level", 32'(w.level), 32'(pin_level[ch]));
        if (int'(w.count) <= last_count[ch]) begin
            $display("sample count %0d of channel %0d did not rise above %0d",
                     w.count, ch, last_count[ch]);
            report_failure();
        end
        last_count[ch] = int'(w.count);
    endtask

    // pops cmp_count words and compares them with the reference records
    initial begin : compare_fifo
        logic [31:0] raw;
        forever begin
            wait (cmp_busy);
            for (int n = 1; n <= cmp_count; n++) begin
                axil_read(global_addr(REG_FIFO_DATA), raw);
                check_value("fifo_data", raw, expected_sample(cmp_chan, n, cmp_level));
            end
            cmp_busy = 1'b0;
        end
    end

    initial begin : main
        logic [31:0] rd;
        logic [31:0] v_step;
        logic [31:0] v_end;
        logic [31:0] t_end;
        logic [31:0] rec_start;
        logic [31:0] rnd;
        int          toggles;
        int          exp_toggles;
        logic        prev;

        seed           = 32'hf632d99e;
        reset          = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        pin_level      = '0;
        for (int i = 0; i < NUM_PINS; i++)
            last_count[i] = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // state right after reset
        axil_read(global_addr(REG_FIFO_DATA), rd);
        check_value("empty fifo_data", rd, 32'd0);
        axil_read(global_addr(REG_FIFO_COUNT), rd);
        check_value("fifo_count", rd, 32'd0);
        axil_read(global_addr(REG_TIME), rd);
        check_value("time", rd, 32'd0);
        check_value("pin_oe", 32'(pin_oe), 32'd0);
        check_value("pin_out", 32'(pin_out), 32'd0);

        v_step = $random(seed);
        v_end  = $random(seed);
        axil_write(channel_addr(2, REG_NCO_STEP), v_step);
        axil_write(channel_addr(2, REG_END_TIME), v_end);
        axil_read(channel_addr(2, REG_NCO_STEP), rd);
        check_value("ch2 nco_step", rd, v_step);
        axil_read(channel_addr(2, REG_END_TIME), rd);
        check_value("ch2 end_time", rd, v_end);
        axil_read(12'h218, rd); // word 6 of channel 2
        check_value("unmapped 0x218", rd, 32'd0);
        axil_read(12'h500, rd);
        check_value("unmapped 0x500", rd, 32'd0);
        axil_read(12'hf14, rd);
        check_value("unmapped 0xf14", rd, 32'd0);

        // constant drive on channel 0 until its end time
        axil_write(global_addr(REG_CTRL), 32'd3);
        axil_read(global_addr(REG_TIME), rd);
        t_end = rd + 32'd60;
        axil_write(channel_addr(0, REG_END_TIME), t_end);
        axil_write(channel_addr(0, REG_CMD), CMD_CONST);
        wait_oe(0, 1'b1);
        check_value("pin_out[0]", 32'(pin_out[0]), 32'd1);
        wait_time_past(t_end);
        check_value("pin_oe[0]", 32'(pin_oe[0]), 32'd0);
        check_value("pin_out[0]", 32'(pin_out[0]), 32'd0);
        axil_read(channel_addr(0, REG_STATUS), rd);
        check_value("ch0 state", rd & 32'hf, 32'(ST_IDLE));

        // the square wave toggles once every 2^31 / step cycles
        v_step = 32'h1000_0000;
        axil_write(channel_addr(1, REG_NCO_STEP), v_step);
        axil_write(channel_addr(1, REG_CMD), CMD_SQUARE);
        wait_oe(1, 1'b1);
        toggles     = 0;
        exp_toggles = int'((64'd512 * 64'(v_step)) >> 31);
        prev        = pin_out[1];
        repeat (512) begin
            @(negedge clk);
            if (pin_out[1] !== prev)
                toggles++;
            prev = pin_out[1];
        end
        if (toggles < exp_toggles - 1 || toggles > exp_toggles + 1) begin
            $display("pin_out[1] toggled %0d times in 512 cycles, expected %0d give or take one",
                     toggles, exp_toggles);
            report_failure();
        end
        axil_write(channel_addr(1, REG_CMD), CMD_STOP);
        wait_oe(1, 1'b0);
        check_value("pin_out[1]", 32'(pin_out[1]), 32'd0);

        // channel 3 records a held level every 8 cycles and takes five samples before the end
        rnd = $random(seed);
        @(negedge clk);
        pin_level[3] = rnd[0];
        axil_read(global_addr(REG_TIME), rd);
        rec_start = rd + 32'd40;
        t_end     = rec_start + 32'd36;
        axil_write(channel_addr(3, REG_SAMPLE_RATE), 32'd7);
        axil_write(channel_addr(3, REG_REC_START), rec_start);
        axil_write(channel_addr(3, REG_END_TIME), t_end);
        axil_write(channel_addr(3, REG_CMD), CMD_STREAM);
        wait_time_past(t_end);
        axil_read(global_addr(REG_FIFO_COUNT), rd);
        check_value("fifo_count after stream", rd, 32'd5);
        cmp_count = int'(rd);
        cmp_chan  = 3;
        cmp_level = pin_level[3];
        cmp_busy  = 1'b1;
        wait (!cmp_busy);
        axil_read(global_addr(REG_FIFO_COUNT), rd);
        check_value("fifo_count after pops", rd, 32'd0);

        // two channels sampling every cycle fill the fifo while nobody reads
        axil_read(global_addr(REG_TIME), rd);
        rec_start = rd + 32'd60;
        for (int ch = 0; ch <= 2; ch += 2) begin
            axil_write(channel_addr(ch, REG_END_TIME), 32'd0);
            axil_write(channel_addr(ch, REG_SAMPLE_RATE), 32'd0);
            axil_write(channel_addr(ch, REG_REC_START), rec_start);
            axil_write(channel_addr(ch, REG_CMD), CMD_STREAM);
        end
        rd = '0;
        while (rd != 32'(FIFO_DEPTH))
            axil_read(global_addr(REG_FIFO_COUNT), rd);
        axil_read(channel_addr(0, REG_STATUS), v_step);
        axil_read(channel_addr(2, REG_STATUS), v_end);
        if (!v_step[STATUS_OVERRUN_BIT] && !v_end[STATUS_OVERRUN_BIT]) begin
            $display("neither channel 0 nor channel 2 shows an overrun with the fifo full");
            report_failure();
        end
        axil_write(channel_addr(0, REG_CMD), CMD_STOP);
        axil_write(channel_addr(2, REG_CMD), CMD_STOP);
        for (int i = 0; i < FIFO_DEPTH; i++)
            pop_stream_word();
        axil_read(global_addr(REG_FIFO_COUNT), rd);
        while (rd != 32'd0) begin  // records still pending in the channels follow
            pop_stream_word();
            axil_read(global_addr(REG_FIFO_COUNT), rd);
        end
        check_value("pin_oe", 32'(pin_oe), 32'd0);
        check_value("pin_out", 32'(pin_out), 32'd0);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/pin_seq_pkg.sv
rtl/time_base.sv
rtl/axil_reg_port.sv
rtl/pin_channel.sv
rtl/sample_collector.sv
rtl/sample_fifo.sv
rtl/pin_seq_top.sv
tb/tb_pin_seq.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_pin_seq \
        -f compile.f -Mdir obj_dir -o tb_pin_seq; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_pin_seq > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1
